/* Bender.yml */
package:
  name: issue_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/instr_pkg.sv
      - verilog/pipe_pkg.sv
      - verilog/issue_queue.sv
      - verilog/pair_hazard.sv
      - verilog/operand_fetch.sv
      - verilog/issue_select.sv
      - verilog/issue_top.sv
      - bench/issue_checker.sv
      - bench/issue_tb.sv

/* bench/issue_checker.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_checker
    import instr_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  decode_pkt_t [1:0] in,
    input  logic [1:0]        hit,
    input  logic              stall_issue,
    input  logic              flush_issue,
    input  logic              stall_exec,
    input  logic              flush_exec,
    input  regfile_write_t    wb,
    input  logic              queue_full,
    input  issue_pkt_t [1:0]  out,
    input  logic [2:0]        phase,
    input  logic              final_check,
    output int                value_errors,
    output int                other_errors
);

    string names [7] = '{"init", "order", "full", "pairing", "operands", "stall_flush", "drain"};
    decode_pkt_t model_q [$];
    word_t model_rf [`REG_COUNT];
    issue_pkt_t [1:0] exp_out;

    function automatic logic is_bj(input decode_pkt_t d);
        return d.ctl.branch || d.ctl.jump || d.ctl.jr;
    endfunction

    function automatic issue_pkt_t expect_pkt(input decode_pkt_t d, input logic slot_a);
        issue_pkt_t p;
        word_t w;
        w = d.instr;
        p.valid = 1'b1;
        p.dec = d;
        p.rtval = (w[20:16] == 5'd0) ? '0 : model_rf[w[20:16]];
        p.srca = (w[25:21] == 5'd0) ? '0 : model_rf[w[25:21]];
        // only the head slot carries the return address of a linking instruction
        if (slot_a && d.ctl.is_link)
            p.srca = d.pc + 32'd8;
        p.srcb = d.ctl.use_imm ? {{16{w[15]}}, w[15:0]} : p.rtval;
        return p;
    endfunction

    function automatic logic may_pair(input decode_pkt_t a, input decode_pkt_t b);
        word_t w;
        logic raw;
        w = b.instr;
        raw = a.ctl.regwrite && a.destreg != 5'd0 &&
              (a.destreg == w[25:21] || a.destreg == w[20:16]);
        return !is_bj(b) && !raw &&
               !((a.ctl.memtoreg || a.ctl.memwrite) && (b.ctl.memtoreg || b.ctl.memwrite));
    endfunction

    task automatic compare(input string what, input logic [$bits(issue_pkt_t)-1:0] exp,
                           input logic [$bits(issue_pkt_t)-1:0] act);
        if (act !== exp)
        begin
            value_errors++;
            $display("FAIL %s %s expected %0h actual %0h", names[phase], what, exp, act);
        end
    endtask

    initial
    begin
        value_errors = 0;
        other_errors = 0;
    end

    // inputs and outputs both settle between rising edges
    always @(negedge clk)
    begin : model_step
        issue_pkt_t pa;
        issue_pkt_t pb;
        logic en_a;
        logic en_b;
        logic full;
        if (reset)
        begin
            model_q.delete();
            exp_out = '0;
        end
        else
        begin
            full = int'(hit[1]) + int'(hit[0]) > `ISSUE_QUEUE_DEPTH - model_q.size();
            compare("queue_full", full, queue_full);
            compare("out[1]", exp_out[1], out[1]);
            compare("out[0]", exp_out[0], out[0]);
            if (final_check && model_q.size() != 0)
            begin
                other_errors++;
                $display("%0d queued packets were never issued", model_q.size());
            end
            pa = '0;
            pb = '0;
            en_a = 1'b0;
            en_b = 1'b0;
            if (model_q.size() > 0)
            begin
                pa = expect_pkt(model_q[0], 1'b1);
                // a branch waits for its delay slot
                en_a = !is_bj(model_q[0]) || model_q.size() > 1;
            end
            if (en_a && model_q.size() > 1)
            begin
                pb = expect_pkt(model_q[1], 1'b0);
                en_b = may_pair(model_q[0], model_q[1]) || is_bj(model_q[0]);
            end
            if (flush_exec)
                exp_out = '0;
            else if (!stall_exec)
            begin
                exp_out[1] = (en_a && !stall_issue) ? pa : '0;
                exp_out[0] = (en_b && !stall_issue) ? pb : '0;
            end
            if (flush_issue)
                model_q.delete();
            else
            begin
                if (!stall_issue && !stall_exec && en_a)
                    void'(model_q.pop_front());
                if (!stall_issue && !stall_exec && en_b)
                    void'(model_q.pop_front());
                if (!full && hit[1])
                    model_q.push_back(in[1]);
                if (!full && hit[0])
                    model_q.push_back(in[0]);
            end
            // the write lands after this cycle's reads
            if (wb.we && wb.addr != 5'd0)
                model_rf[wb.addr] = wb.data;
        end
    end

endmodule

/* bench/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb
    import instr_pkg::*, pipe_pkg::*;
();

    localparam int PHASE_CYCLES = 300;
    // reset, register init, five test phases and the drain
    localparam int TOTAL_CYCLES = 5 + 32 + 6 * PHASE_CYCLES + 2;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * 8;

    logic clk;
    logic reset;
    decode_pkt_t [1:0] in;
    logic [1:0] hit;
    logic stall_issue, flush_issue, stall_exec, flush_exec;
    regfile_write_t wb;
    logic queue_full;
    issue_pkt_t [1:0] out;
    logic [2:0] phase;
    logic final_check;
    logic retry;
    logic [31:0] rng;
    int value_errors, other_errors;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic decode_pkt_t make_pkt(input logic [2:0] ph);
        decode_pkt_t p;
        logic [31:0] r;
        logic [31:0] c;
        logic [2:0] lim;
        r = rand32();
        c = rand32();
        // pairing and operand phases crowd rs and rt onto r0 to r3
        if (ph == 3'd3 || ph == 3'd4)
            r = r & 32'hfc63_ffff;
        lim = (ph == 3'd3) ? 3'd2 : 3'd1;
        p.instr = r;
        p.pc = {16'h0040, c[15:2], 2'b00};
        p.destreg = (ph == 3'd3 || ph == 3'd4) ? {3'b000, c[17:16]} : c[20:16];
        p.ctl.regwrite = c[21];
        p.ctl.use_imm = c[22];
        p.ctl.memtoreg = c[25:23] < lim;
        p.ctl.memwrite = c[28:26] < lim;
        p.ctl.branch = c[31:29] < lim;
        p.ctl.jump = c[31:29] == 3'd7;
        p.ctl.jr = c[31:29] == 3'd6 && c[0];
        p.ctl.is_link = c[1] && (p.ctl.branch || p.ctl.jump);
        return p;
    endfunction

    task automatic drive_cycle(input logic [2:0] ph, input int idx);
        logic [31:0] r;
        r = rand32();
        // a refused pair is held for another try
        if (!retry)
        begin
            in[1] <= (ph == 3'd6) ? decode_pkt_t'('0) : make_pkt(ph);
            in[0] <= (ph == 3'd6) ? decode_pkt_t'('0) : make_pkt(ph);
            if (ph == 3'd6)
                hit <= (idx < 8) ? 2'b11 : 2'b00;
            else if (ph == 3'd2)
                hit <= (r[3:2] != 2'b00) ? 2'b11 : r[1:0];
            else
                hit <= r[1:0];
        end
        stall_exec <= (ph == 3'd2 && r[5:4] != 2'b00) || (ph == 3'd5 && r[7:6] == 2'b00);
        stall_issue <= ph == 3'd5 && r[9:8] == 2'b00;
        flush_issue <= ph == 3'd5 && r[13:10] == 4'd0;
        flush_exec <= ph == 3'd5 && r[17:14] == 4'd0;
        wb.we <= r[18];
        wb.addr <= (ph == 3'd4) ? {3'b000, r[20:19]} : r[23:19];
        wb.data <= rand32();
    endtask

    issue_top issue_top_i (.clk, .reset, .in, .hit, .stall_issue, .flush_issue, .stall_exec,
                           .flush_exec, .wb, .queue_full, .out);

    issue_checker issue_checker_i (.clk, .reset, .in, .hit, .stall_issue, .flush_issue,
                                   .stall_exec, .flush_exec, .wb, .queue_full, .out, .phase,
                                   .final_check, .value_errors, .other_errors);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        rng = 32'd46630;
        reset = 1'b1;
        in = '0;
        hit = 2'b00;
        stall_issue = 1'b0;
        flush_issue = 1'b0;
        stall_exec = 1'b0;
        flush_exec = 1'b0;
        wb = '0;
        phase = 3'd0;
        final_check = 1'b0;
        retry = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // every register gets a defined value, r0 included
        for (int i = 0; i < 32; i++)
        begin
            @(posedge clk);
            wb <= '{we: 1'b1, addr: reg_addr_t'(i), data: rand32()};
        end
        for (int ph = 1; ph <= 6; ph++)
        begin
            for (int i = 0; i < PHASE_CYCLES; i++)
            begin
                @(negedge clk);
                retry = queue_full;
                @(posedge clk);
                phase <= 3'(ph);
                drive_cycle(3'(ph), i);
            end
        end
        @(posedge clk);
        final_check <= 1'b1;
        @(posedge clk);
        #1;
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("tests failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/instr_pkg.sv
verilog/pipe_pkg.sv
verilog/issue_queue.sv
verilog/pair_hazard.sv
verilog/operand_fetch.sv
verilog/issue_select.sv
verilog/issue_top.sv
bench/issue_checker.sv
bench/issue_tb.sv

/* verilog/instr_pkg.sv */
package instr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // control bits produced by decode
    typedef struct packed {
        logic regwrite;
        logic memtoreg;
        logic memwrite;
        logic branch;
        logic jump;
        logic jr;
        logic is_link;
        logic use_imm;
    } ctl_t;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // same instruction word seen as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

    typedef struct packed {
        instr_word_u instr;
        ctl_t        ctl;
        reg_addr_t   destreg;
        word_t       pc;
    } decode_pkt_t;

endpackage

/* verilog/issue_consts.svh */
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// issue queue depth, must stay a power of two
`define ISSUE_QUEUE_DEPTH 8

// pointer width into the issue queue, log2 of the depth
`define ISSUE_PTR_W 3

// architectural register file size
`define REG_COUNT 32

`endif

/* verilog/issue_queue.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_queue
    import instr_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  decode_pkt_t [1:0] in,
    input  logic [1:0]        hit,
    input  logic [1:0]        deq,
    input  logic              flush_issue,
    output logic              queue_full,
    output head_pair_t        head
);

    decode_pkt_t entries [`ISSUE_QUEUE_DEPTH];
    logic [`ISSUE_QUEUE_DEPTH-1:0] valid;
    logic [`ISSUE_QUEUE_DEPTH-1:0] valid_next;
    logic [`ISSUE_PTR_W-1:0] head_ptr, head_ptr1;
    logic [`ISSUE_PTR_W-1:0] tail_ptr, tail_ptr1;
    logic [`ISSUE_PTR_W-1:0] wr0_ptr;
    logic [1:0] n_hit, n_deq;

    assign head_ptr1 = head_ptr + `ISSUE_PTR_W'(1);
    assign tail_ptr1 = tail_ptr + `ISSUE_PTR_W'(1);
    assign n_hit = {1'b0, hit[1]} + {1'b0, hit[0]};
    assign n_deq = {1'b0, deq[1]} + {1'b0, deq[0]};

    // entries stay contiguous, so free slots start at the tail
    assign queue_full = (hit != 2'b00 && valid[tail_ptr]) || (hit == 2'b11 && valid[tail_ptr1]);

    // slot 0 alone takes the tail, behind slot 1 otherwise
    assign wr0_ptr = hit[1] ? tail_ptr1 : tail_ptr;

    assign head.a_valid = valid[head_ptr];
    assign head.a = entries[head_ptr];
    assign head.b_valid = valid[head_ptr1];
    assign head.b = entries[head_ptr1];

    always_comb
    begin
        valid_next = valid;
        if (deq[1])
            valid_next[head_ptr] = 1'b0;
        if (deq[0])
            valid_next[head_ptr1] = 1'b0;
        if (!queue_full && hit[1])
            valid_next[tail_ptr] = 1'b1;
        if (!queue_full && hit[0])
            valid_next[wr0_ptr] = 1'b1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            valid <= '0;
        end
        else if (flush_issue)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            valid <= '0;
        end
        else
        begin
            valid <= valid_next;
            head_ptr <= head_ptr + `ISSUE_PTR_W'(n_deq);
            if (!queue_full)
                tail_ptr <= tail_ptr + `ISSUE_PTR_W'(n_hit);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!flush_issue && !queue_full)
        begin
            if (hit[1])
                entries[tail_ptr] <= in[1];
            if (hit[0])
                entries[wr0_ptr] <= in[0];
        end
    end

    // the select stage only removes entries that hold a packet
    a_deq_valid: assert property (@(posedge clk) disable iff (reset)
        (deq[1] -> valid[head_ptr]) && (deq[0] -> valid[head_ptr1]));

    // a refused accept fills no entry
    a_full_no_write: assert property (@(posedge clk) disable iff (reset)
        queue_full && !flush_issue |=> (valid & ~$past(valid)) == '0);

endmodule

/* verilog/issue_select.sv */
`timescale 1ns/1ps

module issue_select
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  issue_pkt_t       pkt_a,
    input  issue_pkt_t       pkt_b,
    input  logic             pair_ok,
    input  logic             a_wait,
    input  logic             stall_issue,
    input  logic             stall_exec,
    input  logic             flush_exec,
    output logic [1:0]       deq,
    output issue_pkt_t [1:0] out
);

    logic a_bj;
    logic en_a;
    logic en_b;
    logic advance;

    assign a_bj = pkt_a.dec.ctl.branch || pkt_a.dec.ctl.jump || pkt_a.dec.ctl.jr;

    assign en_a = pkt_a.valid && !a_wait;
    // the delay slot always follows its branch
    assign en_b = en_a && pkt_b.valid && (pair_ok || a_bj);

    // either stall keeps the queue where it is
    assign advance = !stall_issue && !stall_exec;
    assign deq = advance ? {en_a, en_b} : 2'b00;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            out <= '0;
        end
        else if (flush_exec)
        begin
            out <= '0;
        end
        else if (!stall_exec)
        begin
            if (stall_issue)
            begin
                out <= '0;
            end
            else
            begin
                out[1] <= en_a ? pkt_a : '0;
                out[0] <= en_b ? pkt_b : '0;
            end
        end
    end

    // slot 0 never goes without the older slot 1
    a_out_order: assert property (@(posedge clk) disable iff (reset)
        out[0].valid |-> out[1].valid);

endmodule

/* verilog/issue_top.sv */
`timescale 1ns/1ps

module issue_top
    import instr_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  decode_pkt_t [1:0] in,
    input  logic [1:0]        hit,
    input  logic              stall_issue,
    input  logic              flush_issue,
    input  logic              stall_exec,
    input  logic              flush_exec,
    input  regfile_write_t    wb,
    output logic              queue_full,
    output issue_pkt_t [1:0]  out
);

    head_pair_t head;
    logic pair_ok, a_wait;
    issue_pkt_t pkt_a, pkt_b;
    logic [1:0] deq;

    issue_queue issue_queue_i (.clk, .reset, .in, .hit, .deq, .flush_issue, .queue_full, .head);

    pair_hazard pair_hazard_i (.head, .pair_ok, .a_wait);

    operand_fetch operand_fetch_i (.clk, .reset, .head, .wb, .pkt_a, .pkt_b);

    issue_select issue_select_i (.clk, .reset, .pkt_a, .pkt_b, .pair_ok, .a_wait,
                                 .stall_issue, .stall_exec, .flush_exec, .deq, .out);

endmodule

/* verilog/operand_fetch.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module operand_fetch
    import instr_pkg::*, pipe_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  head_pair_t     head,
    input  regfile_write_t wb,
    output issue_pkt_t     pkt_a,
    output issue_pkt_t     pkt_b
);

    word_t regs [`REG_COUNT];
    reg_addr_t a_rs, a_rt, b_rs, b_rt;
    word_t a_rs_val, a_rt_val, b_rs_val, b_rt_val;

    function automatic issue_pkt_t build_pkt(
        input logic        v,
        input decode_pkt_t d,
        input word_t       rs_val,
        input word_t       rt_val
    );
        issue_pkt_t p;
        p.valid = v;
        p.dec = d;
        p.srca = rs_val;
        p.srcb = d.ctl.use_imm ? {{16{d.instr.i.imm[15]}}, d.instr.i.imm} : rt_val;
        p.rtval = rt_val;
        return p;
    endfunction

    always_ff @(posedge clk)
    begin
        if (wb.we && wb.addr != '0)
            regs[wb.addr] <= wb.data;
    end

    assign a_rs = head.a.instr.r.rs;
    assign a_rt = head.a.instr.r.rt;
    assign b_rs = head.b.instr.r.rs;
    assign b_rt = head.b.instr.r.rt;

    // four read ports, r0 is hardwired to zero
    assign a_rs_val = (a_rs == '0) ? '0 : regs[a_rs];
    assign a_rt_val = (a_rt == '0) ? '0 : regs[a_rt];
    assign b_rs_val = (b_rs == '0) ? '0 : regs[b_rs];
    assign b_rt_val = (b_rt == '0) ? '0 : regs[b_rt];

    always_comb
    begin
        pkt_a = build_pkt(head.a_valid, head.a, a_rs_val, a_rt_val);
        // link address replaces srca for jal and friends
        if (head.a.ctl.is_link)
            pkt_a.srca = head.a.pc + 32'd8;
    end

    assign pkt_b = build_pkt(head.b_valid, head.b, b_rs_val, b_rt_val);

    // a write to r0 still leaves it reading zero in both packets
    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        wb.we && wb.addr == '0 |=>
            (!pkt_a.valid || a_rt != '0 || pkt_a.rtval == '0) &&
            (!pkt_b.valid || b_rt != '0 || pkt_b.rtval == '0));

endmodule

/* verilog/pair_hazard.sv */
`timescale 1ns/1ps

module pair_hazard
    import instr_pkg::*, pipe_pkg::*;
(
    input  head_pair_t head,
    output logic       pair_ok,
    output logic       a_wait
);

    reg_addr_t b_rs;
    reg_addr_t b_rt;
    logic a_bj;
    logic b_bj;
    logic a_mem;
    logic b_mem;
    logic raw;
    logic mem_pair;

    // source registers of b come from the R-format view
    assign b_rs = head.b.instr.r.rs;
    assign b_rt = head.b.instr.r.rt;

    assign a_bj = head.a.ctl.branch || head.a.ctl.jump || head.a.ctl.jr;
    assign b_bj = head.b.ctl.branch || head.b.ctl.jump || head.b.ctl.jr;

    assign a_mem = head.a.ctl.memtoreg || head.a.ctl.memwrite;
    assign b_mem = head.b.ctl.memtoreg || head.b.ctl.memwrite;

    // b reads what a is about to write, r0 excluded
    assign raw = head.a.ctl.regwrite && head.a.destreg != '0 &&
                 (head.a.destreg == b_rs || head.a.destreg == b_rt);

    // only one memory port in execute
    assign mem_pair = a_mem && b_mem;

    assign pair_ok = !(b_bj || raw || mem_pair);

    // hold a branch until its delay slot is in the queue
    assign a_wait = a_bj && !head.b_valid;

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;
    import instr_pkg::*;

    typedef struct packed {
        logic        valid;
        decode_pkt_t dec;
        word_t       srca;
        word_t       srcb;
        word_t       rtval;
    } issue_pkt_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } regfile_write_t;

    // a is the oldest entry, b the one behind it
    typedef struct packed {
        logic        a_valid;
        decode_pkt_t a;
        logic        b_valid;
        decode_pkt_t b;
    } head_pair_t;

endpackage
